// File: source/gps_code_pkg.sv
// Vector typedefs shared by the GPS ranging code subsystem
// Round-state enum for the round controller

`default_nettype none

package gps_code_pkg;

    // Space-vehicle number, valid range 1 to 32
    typedef logic [5:0] sv_num_t;

    // First 13 C/A chips, first chip in the MSB
    typedef logic [12:0] ca_code_t;

    // 128 captured P chips, first chip in the MSB
    // Also carries the scrambled l_code block
    typedef logic [127:0] p_block_t;

    // Chip counter for both generators
    typedef logic [7:0] chip_cnt_t;

    // Round controller states
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } round_state_t;

endpackage

`default_nettype wire

// File: source/gps_prn_pkg.sv
// C/A G2 phase-select taps per SV, P-code LFSR seeds and polynomials
// Galois polynomial of the l_code keystream

`default_nettype none

package gps_prn_pkg;

    // Two G2 stage numbers (1 to 10), [1] is the first tap
    typedef logic [1:0][3:0] ca_tap_pair_t;

    // Phase-select pairs for PRN 1 to 32, index 0 is PRN 1
    localparam ca_tap_pair_t CA_G2_TAPS [32] = '{
        8'h26, 8'h37, 8'h48, 8'h59, 8'h19, 8'h2A, 8'h18, 8'h29,
        8'h3A, 8'h23, 8'h34, 8'h56, 8'h67, 8'h78, 8'h89, 8'h9A,
        8'h14, 8'h25, 8'h36, 8'h47, 8'h58, 8'h69, 8'h13, 8'h46,
        8'h57, 8'h68, 8'h79, 8'h8A, 8'h16, 8'h27, 8'h38, 8'h49
    };

    // Feedback masks, bit k is shift-register stage k+1
    // G1 = 1 + x^3 + x^10, G2 = 1 + x^2 + x^3 + x^6 + x^8 + x^9 + x^10
    localparam logic [9:0] CA_G1_POLY = 10'h204;
    localparam logic [9:0] CA_G2_POLY = 10'h3A6;

    // 12-bit maximal polynomials for the P-like code
    localparam logic [11:0] P_X1_POLY = 12'h829;
    localparam logic [11:0] P_X2_POLY = 12'hE08;

    localparam logic [11:0] P_X1_SEED = 12'hFFF;

    // X2 initial state per SV, index 0 is SV 1
    localparam logic [11:0] P_X2_SEEDS [32] = '{
        12'h001, 12'h0A3, 12'h15C, 12'h2E7, 12'h3B1, 12'h44D, 12'h512, 12'h6F8,
        12'h7C4, 12'h839, 12'h96E, 12'hA07, 12'hB95, 12'hC2A, 12'hDD3, 12'hE6B,
        12'hF10, 12'h0F5, 12'h1E2, 12'h27C, 12'h389, 12'h4B6, 12'h563, 12'h6A1,
        12'h70E, 12'h8D7, 12'h94B, 12'hAB2, 12'hB3F, 12'hC68, 12'hDA5, 12'hE1C
    };

    // Right-shift Galois mask, taps 32, 22, 2, 1
    localparam logic [31:0] SCR_POLY = 32'h8020_0003;

endpackage

`default_nettype wire

// File: source/gps_round_ctrl.sv
// Round controller: start-edge detection and IDLE/RUN/FINISH FSM
// Holds code_gen_en until both the C/A path and the scrambler are done

`timescale 1ns/1ns
`default_nettype none

module gps_round_ctrl import gps_code_pkg::*;
(
    input  logic gps_clk_fast,
    input  logic sync_rst_in,
    input  logic start_round,
    input  logic ca_done,
    input  logic l_code_valid,
    output logic round_start,
    output logic code_gen_en
);

    round_state_t state;
    logic         start_q;
    logic         lv_seen;
    logic         round_done;

    // Rising edge against last cycle's level
    assign round_start = start_round & ~start_q;

    // Scrambler pulse may come before or after ca_done
    assign round_done = ca_done & (l_code_valid | lv_seen);

    always_ff @(posedge gps_clk_fast)
    begin
        if (sync_rst_in)
        begin
            start_q     <= 1'b0;
            state       <= IDLE;
            code_gen_en <= 1'b0;
            lv_seen     <= 1'b0;
        end
        else
        begin
            start_q <= start_round;
            if (round_start)
            begin
                // A new edge restarts the round from any state
                state       <= RUN;
                code_gen_en <= 1'b1;
                lv_seen     <= 1'b0;
            end
            else
            begin
                case (state)
                    RUN:
                    begin
                        if (l_code_valid)
                            lv_seen <= 1'b1;
                        if (round_done)
                        begin
                            state       <= FINISH;
                            code_gen_en <= 1'b0;
                        end
                    end
                    FINISH:
                    begin
                        lv_seen <= 1'b0;
                        state   <= IDLE;
                    end
                    default:
                        state <= IDLE;
                endcase
            end
        end
    end

    // Scrambler output only arrives inside a round
    a_valid_in_round: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        l_code_valid |-> code_gen_en);

    // C/A path completes only while a round runs
    a_ca_done_in_run: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        $rose(ca_done) |-> (state == RUN));

endmodule

`default_nettype wire

// File: source/ca_code_gen.sv
// C/A Gold code generator for one SV
// Chip-rate divider, G1/G2 shift registers and 13-chip capture

`timescale 1ns/1ns
`default_nettype none

module ca_code_gen import gps_code_pkg::*, gps_prn_pkg::*;
#(
    parameter int CA_DIV = 10
)
(
    input  logic     gps_clk_fast,
    input  logic     sync_rst_in,
    input  logic     round_start,
    input  logic     code_gen_en,
    input  sv_num_t  sv_num,
    output ca_code_t ca_code,
    output logic     ca_done
);

    localparam int DIV_W = (CA_DIV > 1) ? $clog2(CA_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    chip_cnt_t        chip_cnt;
    logic             chip_en;
    logic             ca_chip;
    logic [4:0]       sv_idx;
    ca_tap_pair_t     taps_q;

    // Bit k holds stage k+1, stage 10 is the output end
    logic [9:0] g1;
    logic [9:0] g2;

    assign sv_idx = 5'(sv_num - 6'd1);

    // One chip every CA_DIV fast cycles, first one CA_DIV cycles after start
    assign chip_en = code_gen_en & ~ca_done & (div_cnt == DIV_W'(CA_DIV - 1));

    // G1 output XOR the two phase-selected G2 stages
    assign ca_chip = g1[9] ^ g2[taps_q[1] - 4'd1] ^ g2[taps_q[0] - 4'd1];

    always_ff @(posedge gps_clk_fast)
    begin
        if (sync_rst_in)
        begin
            div_cnt  <= '0;
            chip_cnt <= '0;
            ca_code  <= '0;
            ca_done  <= 1'b0;
        end
        else if (round_start)
        begin
            div_cnt  <= '0;
            chip_cnt <= '0;
            ca_code  <= '0;
            ca_done  <= 1'b0;
        end
        else if (code_gen_en && !ca_done)
        begin
            if (chip_en)
            begin
                div_cnt  <= '0;
                ca_code  <= {ca_code[11:0], ca_chip};
                chip_cnt <= chip_cnt + 8'd1;
                // Done once the 13th chip is held
                if (chip_cnt == 8'd12)
                    ca_done <= 1'b1;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Shift registers are seeded before first use
    always_ff @(posedge gps_clk_fast)
    begin
        if (round_start)
        begin
            g1     <= '1;
            g2     <= '1;
            taps_q <= CA_G2_TAPS[sv_idx];
        end
        else if (chip_en)
        begin
            g1 <= {g1[8:0], ^(g1 & CA_G1_POLY)};
            g2 <= {g2[8:0], ^(g2 & CA_G2_POLY)};
        end
    end

    a_sv_range: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        round_start |-> (sv_num >= 6'd1 && sv_num <= 6'd32));

endmodule

`default_nettype wire

// File: source/p_code_gen.sv
// P-like code generator, XOR of two 12-bit maximal LFSRs
// X2 seed chosen per SV, 128-chip capture and done pulse

`timescale 1ns/1ns
`default_nettype none

module p_code_gen import gps_code_pkg::*, gps_prn_pkg::*;
(
    input  logic     gps_clk_fast,
    input  logic     sync_rst_in,
    input  logic     round_start,
    input  logic     code_gen_en,
    input  sv_num_t  sv_num,
    output p_block_t p_code,
    output logic     p_done
);

    chip_cnt_t   chip_cnt;
    logic        capture;
    logic        p_chip;
    logic [4:0]  sv_idx;

    // Bit k holds stage k+1, stage 12 is the output end
    logic [11:0] x1;
    logic [11:0] x2;

    assign sv_idx = 5'(sv_num - 6'd1);

    // One chip per fast cycle until 128 are held
    assign capture = code_gen_en & (chip_cnt < 8'd128);
    assign p_chip  = x1[11] ^ x2[11];

    always_ff @(posedge gps_clk_fast)
    begin
        if (sync_rst_in)
        begin
            chip_cnt <= '0;
            p_code   <= '0;
            p_done   <= 1'b0;
        end
        else if (round_start)
        begin
            chip_cnt <= '0;
            p_code   <= '0;
            p_done   <= 1'b0;
        end
        else
        begin
            p_done <= 1'b0;
            if (capture)
            begin
                p_code   <= {p_code[126:0], p_chip};
                chip_cnt <= chip_cnt + 8'd1;
                // High for the cycle after the 128th chip
                if (chip_cnt == 8'd127)
                    p_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge gps_clk_fast)
    begin
        if (round_start)
        begin
            x1 <= P_X1_SEED;
            x2 <= P_X2_SEEDS[sv_idx];
        end
        else if (capture)
        begin
            x1 <= {x1[10:0], ^(x1 & P_X1_POLY)};
            x2 <= {x2[10:0], ^(x2 & P_X2_POLY)};
        end
    end

endmodule

`default_nettype wire

// File: source/lcode_scrambler.sv
// Keyed stream scrambler producing l_code from the captured P block
// 32-bit Galois LFSR keystream, one byte per cycle over 16 cycles

`timescale 1ns/1ns
`default_nettype none

module lcode_scrambler import gps_code_pkg::*, gps_prn_pkg::*;
#(
    parameter logic [31:0] LCODE_KEY = 32'hAAAA_AAAA
)
(
    input  logic     gps_clk_fast,
    input  logic     sync_rst_in,
    input  logic     round_start,
    input  logic     p_done,
    input  p_block_t p_code,
    output p_block_t l_code,
    output logic     l_code_valid
);

    logic        busy;
    logic [3:0]  byte_cnt;
    logic [31:0] lfsr;
    logic [31:0] lfsr_nx;
    logic [7:0]  ks_byte;
    p_block_t    work;
    p_block_t    work_nx;

    // Eight Galois steps, first output bit lands in the byte MSB
    always_comb
    begin
        lfsr_nx = lfsr;
        ks_byte = '0;
        for (int i = 0; i < 8; i++)
        begin
            ks_byte = {ks_byte[6:0], lfsr_nx[0]};
            lfsr_nx = (lfsr_nx >> 1) ^ (lfsr_nx[0] ? SCR_POLY : 32'd0);
        end
    end

    // Top byte gets the keystream and rotates to the bottom,
    // so after 16 steps the byte order is back in place
    assign work_nx = {work[119:0], work[127:120] ^ ks_byte};

    always_ff @(posedge gps_clk_fast)
    begin
        if (sync_rst_in)
        begin
            busy         <= 1'b0;
            byte_cnt     <= '0;
            l_code       <= '0;
            l_code_valid <= 1'b0;
        end
        else
        begin
            l_code_valid <= 1'b0;
            if (round_start)
            begin
                // Restart aborts any block in flight
                busy     <= 1'b0;
                byte_cnt <= '0;
            end
            else if (p_done)
            begin
                busy     <= 1'b1;
                byte_cnt <= '0;
            end
            else if (busy)
            begin
                byte_cnt <= byte_cnt + 4'd1;
                if (byte_cnt == 4'd15)
                begin
                    busy         <= 1'b0;
                    l_code       <= work_nx;
                    l_code_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge gps_clk_fast)
    begin
        if (p_done && !round_start)
        begin
            work <= p_code;
            lfsr <= LCODE_KEY;
        end
        else if (busy)
        begin
            work <= work_nx;
            lfsr <= lfsr_nx;
        end
    end

    a_no_overlap: assert property (@(posedge gps_clk_fast) disable iff (sync_rst_in)
        p_done |-> !busy);

endmodule

`default_nettype wire

// File: source/gps_code_top.sv
// Top level of the GPS ranging code subsystem
// Round control, C/A and P generators, l_code scrambler

`timescale 1ns/1ns
`default_nettype none

module gps_code_top import gps_code_pkg::*;
#(
    parameter int          CA_DIV    = 10,
    parameter logic [31:0] LCODE_KEY = 32'hAAAA_AAAA
)
(
    input  logic     gps_clk_fast,
    input  logic     sync_rst_in,
    input  sv_num_t  sv_num,
    input  logic     start_round,
    output ca_code_t ca_code,
    output p_block_t p_code,
    output p_block_t l_code,
    output logic     l_code_valid,
    output logic     busy
);

    logic round_start;
    logic code_gen_en;
    logic ca_done;
    logic p_done;

    assign busy = code_gen_en;

    gps_round_ctrl u_round_ctrl
    (
        .gps_clk_fast (gps_clk_fast),
        .sync_rst_in  (sync_rst_in),
        .start_round  (start_round),
        .ca_done      (ca_done),
        .l_code_valid (l_code_valid),
        .round_start  (round_start),
        .code_gen_en  (code_gen_en)
    );

    ca_code_gen #(.CA_DIV(CA_DIV)) u_ca_code_gen
    (
        .gps_clk_fast (gps_clk_fast),
        .sync_rst_in  (sync_rst_in),
        .round_start  (round_start),
        .code_gen_en  (code_gen_en),
        .sv_num       (sv_num),
        .ca_code      (ca_code),
        .ca_done      (ca_done)
    );

    p_code_gen u_p_code_gen
    (
        .gps_clk_fast (gps_clk_fast),
        .sync_rst_in  (sync_rst_in),
        .round_start  (round_start),
        .code_gen_en  (code_gen_en),
        .sv_num       (sv_num),
        .p_code       (p_code),
        .p_done       (p_done)
    );

    lcode_scrambler #(.LCODE_KEY(LCODE_KEY)) u_lcode_scrambler
    (
        .gps_clk_fast (gps_clk_fast),
        .sync_rst_in  (sync_rst_in),
        .round_start  (round_start),
        .p_done       (p_done),
        .p_code       (p_code),
        .l_code       (l_code),
        .l_code_valid (l_code_valid)
    );

endmodule

`default_nettype wire

// File: verification/gps_tb_clk.sv
// Testbench clock and reset source
// 20 ns clock, synchronous reset held high for the first cycles

`timescale 1ns/1ns
`default_nettype none

module gps_tb_clk
#(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 2
)
(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release reset just after an edge, like any other driven input
    initial
    begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// File: verification/tb_gps_code_top.sv
// Testbench for gps_code_top
// Reference models for C/A, P and l_code, typed compare tasks,
// valid checker, restart scenarios, timeout and closing summary

`timescale 1ns/1ns
`default_nettype none

module tb_gps_code_top import gps_code_pkg::*, gps_prn_pkg::*;
();

    localparam logic [31:0] KEY            = 32'hAAAA_AAAA;
    localparam ca_code_t    PRN1_CHIPS     = 13'b1100100000111;
    localparam int          NUM_RANDOM     = 20;
    // Hold round, random rounds, and two restarts that each cost two rounds
    localparam int          NUM_ROUNDS     = 1 + NUM_RANDOM + 4;
    localparam int          TIMEOUT_CYCLES = NUM_ROUNDS * 200 + 100;

    logic     gps_clk_fast;
    logic     sync_rst_in;
    sv_num_t  sv_num;
    logic     start_round;
    ca_code_t ca_code;
    p_block_t p_code;
    p_block_t l_code;
    logic     l_code_valid;
    logic     busy;

    ca_code_t exp_ca;
    p_block_t exp_p;
    p_block_t exp_l;
    int       err_cnt   = 0;
    int       check_cnt = 0;
    int       valid_cnt = 0;
    int       cycle_cnt = 0;

    gps_tb_clk #(.PERIOD_NS(20), .RST_CYCLES(2)) u_clk
    (
        .clk (gps_clk_fast),
        .rst (sync_rst_in)
    );

    gps_code_top dut0
    (
        .gps_clk_fast (gps_clk_fast),
        .sync_rst_in  (sync_rst_in),
        .sv_num       (sv_num),
        .start_round  (start_round),
        .ca_code      (ca_code),
        .p_code       (p_code),
        .l_code       (l_code),
        .l_code_valid (l_code_valid),
        .busy         (busy)
    );

    // ICD Gold code, stages numbered 1 to 10, output at stage 10
    function automatic ca_code_t ref_ca(input sv_num_t sv);
        logic [10:1]  g1;
        logic [10:1]  g2;
        ca_tap_pair_t taps;
        ca_code_t     chips;
        logic         fb1;
        logic         fb2;
        g1    = '1;
        g2    = '1;
        taps  = CA_G2_TAPS[sv - 1];
        chips = '0;
        for (int n = 0; n < 13; n++)
        begin
            chips[12 - n] = g1[10] ^ g2[taps[1]] ^ g2[taps[0]];
            fb1 = g1[3] ^ g1[10];
            fb2 = g2[2] ^ g2[3] ^ g2[6] ^ g2[8] ^ g2[9] ^ g2[10];
            g1  = {g1[9:1], fb1};
            g2  = {g2[9:1], fb2};
        end
        return chips;
    endfunction

    // Two 12-bit LFSRs, feedback from the stages set in each mask
    function automatic p_block_t ref_p(input sv_num_t sv);
        logic [11:0] x1;
        logic [11:0] x2;
        logic        fb1;
        logic        fb2;
        p_block_t    blk;
        x1  = P_X1_SEED;
        x2  = P_X2_SEEDS[sv - 1];
        blk = '0;
        for (int n = 0; n < 128; n++)
        begin
            blk[127 - n] = x1[11] ^ x2[11];
            fb1 = 1'b0;
            fb2 = 1'b0;
            for (int k = 0; k < 12; k++)
            begin
                if (P_X1_POLY[k])
                    fb1 = fb1 ^ x1[k];
                if (P_X2_POLY[k])
                    fb2 = fb2 ^ x2[k];
            end
            x1 = {x1[10:0], fb1};
            x2 = {x2[10:0], fb2};
        end
        return blk;
    endfunction

    // Bit-serial keystream, first keystream bit onto the block MSB
    function automatic p_block_t ref_scramble(input p_block_t blk, input logic [31:0] key);
        logic [31:0] lfsr;
        logic        ks;
        p_block_t    res;
        lfsr = key;
        res  = blk;
        for (int n = 0; n < 128; n++)
        begin
            ks           = lfsr[0];
            res[127 - n] = res[127 - n] ^ ks;
            lfsr         = lfsr >> 1;
            if (ks)
                lfsr = lfsr ^ SCR_POLY;
        end
        return res;
    endfunction

    task automatic check_ca(input string name, input ca_code_t got, input ca_code_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_block(input string name, input p_block_t got, input p_block_t exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_valid_count(input int base);
        check_cnt++;
        if (valid_cnt != base + 1)
        begin
            err_cnt++;
            $display("Round at t=%0t gave %0d l_code_valid pulses instead of one",
                     $time, valid_cnt - base);
        end
    endtask

    // Raise start_round for one SV, expected results set before the edge
    task automatic begin_round(input sv_num_t sv, input logic hold);
        @(posedge gps_clk_fast);
        #2;
        sv_num      = sv;
        start_round = 1'b1;
        exp_p       = ref_p(sv);
        exp_ca      = (sv == 6'd1) ? PRN1_CHIPS : ref_ca(sv);
        exp_l       = ref_scramble(exp_p, KEY);
        @(posedge gps_clk_fast);
        #2;
        if (!hold)
            start_round = 1'b0;
    endtask

    task automatic wait_round_end();
        @(negedge gps_clk_fast);
        while (busy !== 1'b0)
            @(negedge gps_clk_fast);
    endtask

    task automatic report_counts();
        $display("Summary: %0d checks, %0d errors, %0d valid pulses, %0d cycles",
                 check_cnt, err_cnt, valid_cnt, cycle_cnt);
    endtask

    // All three codes are compared on every valid pulse
    always @(negedge gps_clk_fast)
    begin
        if (!sync_rst_in && l_code_valid === 1'b1)
        begin
            valid_cnt++;
            check_ca("ca_code", ca_code, exp_ca);
            check_block("p_code", p_code, exp_p);
            check_block("l_code", l_code, exp_l);
        end
    end

    always @(posedge gps_clk_fast)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, a round never finished", TIMEOUT_CYCLES);
            report_counts();
            $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        int unsigned seed_val;
        int          base;
        sv_num_t     sv;
        sv_num      = 6'd1;
        start_round = 1'b0;
        seed_val    = $urandom(60);

        wait (sync_rst_in === 1'b0);
        @(negedge gps_clk_fast);
        check_flag("busy", busy, 1'b0);
        check_flag("l_code_valid", l_code_valid, 1'b0);
        check_ca("ca_code", ca_code, '0);
        check_block("p_code", p_code, '0);
        check_block("l_code", l_code, '0);

        // PRN 1 with start_round left high after the edge
        base = valid_cnt;
        begin_round(6'd1, 1'b1);
        wait_round_end();
        check_valid_count(base);
        repeat (20)
        begin
            @(negedge gps_clk_fast);
            check_flag("busy", busy, 1'b0);
        end
        check_valid_count(base);
        @(posedge gps_clk_fast);
        #2;
        start_round = 1'b0;

        for (int r = 0; r < NUM_RANDOM; r++)
        begin
            sv   = 6'(($urandom % 32) + 1);
            base = valid_cnt;
            begin_round(sv, 1'b0);
            wait_round_end();
            check_valid_count(base);
        end

        // Restart during P capture, then during scrambling
        base = valid_cnt;
        begin_round(6'd5, 1'b0);
        repeat (70) @(posedge gps_clk_fast);
        begin_round(6'(($urandom % 32) + 1), 1'b0);
        wait_round_end();
        check_valid_count(base);

        base = valid_cnt;
        begin_round(6'd17, 1'b0);
        repeat (136) @(posedge gps_clk_fast);
        begin_round(6'(($urandom % 32) + 1), 1'b0);
        wait_round_end();
        check_valid_count(base);

        report_counts();
        if (err_cnt == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
source/gps_code_pkg.sv
source/gps_prn_pkg.sv
source/gps_round_ctrl.sv
source/ca_code_gen.sv
source/p_code_gen.sv
source/lcode_scrambler.sv
source/gps_code_top.sv
verification/gps_tb_clk.sv
verification/tb_gps_code_top.sv

// File: Bender.yml
package:
  name: gps_code

sources:
  - source/gps_code_pkg.sv
  - source/gps_prn_pkg.sv
  - source/gps_round_ctrl.sv
  - source/ca_code_gen.sv
  - source/p_code_gen.sv
  - source/lcode_scrambler.sv
  - source/gps_code_top.sv
  - target: test
    files:
      - verification/gps_tb_clk.sv
      - verification/tb_gps_code_top.sv
